// File: coll_route_defs.svh
// Collective route unit parameters
`ifndef COLL_ROUTE_DEFS_SVH
`define COLL_ROUTE_DEFS_SVH

// Bits per mesh axis, so the mesh is at most 8 by 8 routers
`define COLL_XY_WIDTH 3

// Number of results the queue can hold
`define COLL_FIFO_DEPTH 4

// Wishbone data width
`define COLL_WB_DW 32

// Word addresses of the register map
`define COLL_ADDR_ID   2'd0
`define COLL_ADDR_REQ  2'd1
`define COLL_ADDR_RES  2'd2
`define COLL_ADDR_STAT 2'd3

`endif

// File: coll_route_pkg.sv
// Collective route types
`include "coll_route_defs.svh"

package coll_route_pkg;

  // One coordinate on a single mesh axis
  typedef logic [`COLL_XY_WIDTH-1:0] coord_t;

  // XY coordinate, x sits above y so the ID register reads x in 5:3
  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_id_t;

  // Collective header as laid out in the REQ register
  // Field order puts dst in the low bits and mask in the high bits
  typedef struct packed {
    xy_id_t mask;
    xy_id_t src_id;
    xy_id_t dst_id;
  } coll_hdr_t;

  // Router ports, the value is the bit index in a route mask
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_dir_e;

  // One bit per router port
  typedef logic [4:0] route_mask_t;

  // Both masks for one header, laid out as bits 9:0 of a RES read
  typedef struct packed {
    route_mask_t exp_in_mask;
    route_mask_t fwd_mask;
  } coll_res_t;

  // Queue occupancy, wide enough to hold the full depth
  typedef logic [2:0] fifo_level_t;

endpackage

// File: coll_route_xymask.sv
// XY collective route masks
`timescale 1ns/1ns

module coll_route_xymask (
  input  coll_route_pkg::coll_hdr_t   hdr_i,
  input  coll_route_pkg::xy_id_t      xy_id_i,
  output coll_route_pkg::route_mask_t fwd_mask_o,
  output coll_route_pkg::route_mask_t exp_in_mask_o
);

  // Header fields split out for readability
  coll_route_pkg::xy_id_t dst_id;
  coll_route_pkg::xy_id_t src_id;
  coll_route_pkg::xy_id_t mask;

  // Outermost coordinates reached by the masked destination and source sets
  coll_route_pkg::xy_id_t dst_max;
  coll_route_pkg::xy_id_t dst_min;
  coll_route_pkg::xy_id_t src_max;
  coll_route_pkg::xy_id_t src_min;

  // Axis membership of this router in the destination or source set
  logic dst_x_match;
  logic dst_y_match;
  logic src_x_match;
  logic src_y_match;

  assign dst_id = hdr_i.dst_id;
  assign src_id = hdr_i.src_id;
  assign mask   = hdr_i.mask;

  // --------------------
  // Set bounds
  // --------------------

  // Setting the masked bits gives the far edge, clearing them the near edge
  assign dst_max.x = dst_id.x | mask.x;
  assign dst_max.y = dst_id.y | mask.y;
  assign dst_min.x = dst_id.x & ~mask.x;
  assign dst_min.y = dst_id.y & ~mask.y;

  assign src_max.x = src_id.x | mask.x;
  assign src_max.y = src_id.y | mask.y;
  assign src_min.x = src_id.x & ~mask.x;
  assign src_min.y = src_id.y & ~mask.y;

  // A bit matches when it is a wildcard or equal to our own coordinate bit
  assign dst_x_match = &(mask.x | ~(xy_id_i.x ^ dst_id.x));
  assign dst_y_match = &(mask.y | ~(xy_id_i.y ^ dst_id.y));
  assign src_x_match = &(mask.x | ~(xy_id_i.x ^ src_id.x));
  assign src_y_match = &(mask.y | ~(xy_id_i.y ^ src_id.y));

  // --------------------
  // Forward mask
  // --------------------

  // Multicast spreads along the source row first and then up and down
  // every column that holds destinations
  always_comb begin
    fwd_mask_o = '0;

    // This router is one of the destinations
    if (dst_x_match && dst_y_match) begin
      fwd_mask_o[coll_route_pkg::Eject] = 1'b1;
    end

    // On the source row, keep going outward while destinations lie beyond us
    if (xy_id_i.y == src_id.y) begin
      if ((xy_id_i.x >= src_id.x) && (xy_id_i.x < dst_max.x)) begin
        fwd_mask_o[coll_route_pkg::East] = 1'b1;
      end
      if ((xy_id_i.x <= src_id.x) && (xy_id_i.x > dst_min.x)) begin
        fwd_mask_o[coll_route_pkg::West] = 1'b1;
      end
    end

    // In a destination column the copy climbs or descends away from the row
    if (dst_x_match) begin
      if ((xy_id_i.y >= src_id.y) && (xy_id_i.y < dst_max.y)) begin
        fwd_mask_o[coll_route_pkg::North] = 1'b1;
      end
      if ((xy_id_i.y <= src_id.y) && (xy_id_i.y > dst_min.y)) begin
        fwd_mask_o[coll_route_pkg::South] = 1'b1;
      end
    end
  end

  // --------------------
  // Expected-input mask
  // --------------------

  // Reduction is the mirror image, rows fold in x first and the result
  // then folds along the destination column
  always_comb begin
    exp_in_mask_o = '0;

    // This router contributes its own operand
    if (src_x_match && src_y_match) begin
      exp_in_mask_o[coll_route_pkg::Eject] = 1'b1;
    end

    // In the destination column, wait for partial results from further out
    if (xy_id_i.x == dst_id.x) begin
      if ((xy_id_i.y >= dst_id.y) && (xy_id_i.y < src_max.y)) begin
        exp_in_mask_o[coll_route_pkg::North] = 1'b1;
      end
      if ((xy_id_i.y <= dst_id.y) && (xy_id_i.y > src_min.y)) begin
        exp_in_mask_o[coll_route_pkg::South] = 1'b1;
      end
    end

    // On a source row, collect from the side that still has sources
    if (src_y_match) begin
      if ((xy_id_i.x >= dst_id.x) && (xy_id_i.x < src_max.x)) begin
        exp_in_mask_o[coll_route_pkg::East] = 1'b1;
      end
      if ((xy_id_i.x <= dst_id.x) && (xy_id_i.x > src_min.x)) begin
        exp_in_mask_o[coll_route_pkg::West] = 1'b1;
      end
    end
  end

  // Every port index has to fit inside the five-bit mask
  initial begin : chk_dir_range
    assert ((int'(coll_route_pkg::North) < $bits(coll_route_pkg::route_mask_t)) &&
            (int'(coll_route_pkg::East)  < $bits(coll_route_pkg::route_mask_t)) &&
            (int'(coll_route_pkg::South) < $bits(coll_route_pkg::route_mask_t)) &&
            (int'(coll_route_pkg::West)  < $bits(coll_route_pkg::route_mask_t)) &&
            (int'(coll_route_pkg::Eject) < $bits(coll_route_pkg::route_mask_t)))
      else $error("route_dir_e value outside route_mask_t");
  end

endmodule

// File: coll_route_stage.sv
// Collective route pipeline stage
`timescale 1ns/1ns

module coll_route_stage (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      valid_i,
  input  coll_route_pkg::coll_hdr_t hdr_i,
  input  coll_route_pkg::xy_id_t    xy_id_i,
  output logic                      valid_o,
  output coll_route_pkg::coll_res_t res_o
);

  // First register holds the issued header
  logic                        hdr_valid_q;
  coll_route_pkg::coll_hdr_t   hdr_q;

  // Mask block outputs for the registered header
  coll_route_pkg::route_mask_t fwd_mask;
  coll_route_pkg::route_mask_t exp_in_mask;

  // Valid bits move through both registers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hdr_valid_q <= 1'b0;
      valid_o     <= 1'b0;
    end else begin
      hdr_valid_q <= valid_i;
      valid_o     <= hdr_valid_q;
    end
  end

  // Header and result only load when a request moves through
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      hdr_q <= hdr_i;
    end
    if (hdr_valid_q) begin
      res_o.fwd_mask    <= fwd_mask;
      res_o.exp_in_mask <= exp_in_mask;
    end
  end

  // Both masks come from one instance
  coll_route_xymask u_xymask (
    .hdr_i         (hdr_q),
    .xy_id_i       (xy_id_i),
    .fwd_mask_o    (fwd_mask),
    .exp_in_mask_o (exp_in_mask)
  );

  // Every issued header leaves as a result exactly two cycles later
  a_valid_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i |-> ##2 valid_o);

endmodule

// File: coll_result_fifo.sv
// Route result queue
`timescale 1ns/1ns
`include "coll_route_defs.svh"

module coll_result_fifo (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        push_i,
  input  coll_route_pkg::coll_res_t   data_i,
  input  logic                        pop_i,
  output coll_route_pkg::coll_res_t   data_o,
  output coll_route_pkg::fifo_level_t level_o,
  output logic                        full_o
);

  localparam int unsigned depth = `COLL_FIFO_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth);

  coll_route_pkg::coll_res_t   mem_q [depth];
  logic [ptr_w-1:0]            wr_ptr_q;
  logic [ptr_w-1:0]            rd_ptr_q;
  coll_route_pkg::fifo_level_t level_q;

  // Step a pointer and wrap at the last entry
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
    ptr_next = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Pointers and level, push and pop can land in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Head entry is visible without a pop
  assign data_o  = mem_q[rd_ptr_q];
  assign level_o = level_q;
  assign full_o  = (level_q == coll_route_pkg::fifo_level_t'(depth));

  // The bus side throttles requests, so these never fire in a sound system
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(push_i && full_o));
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(pop_i && (level_q == '0)));

endmodule

// File: coll_wb_regs.sv
// Wishbone register block
`timescale 1ns/1ns
`include "coll_route_defs.svh"

module coll_wb_regs (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [1:0]                  wb_adr_i,
  input  logic [`COLL_WB_DW-1:0]      wb_dat_i,
  output logic [`COLL_WB_DW-1:0]      wb_dat_o,
  output logic                        wb_ack_o,
  output logic                        issue_valid_o,
  output coll_route_pkg::coll_hdr_t   issue_hdr_o,
  output coll_route_pkg::xy_id_t      router_id_o,
  output logic                        fifo_pop_o,
  input  coll_route_pkg::coll_res_t   fifo_data_i,
  input  coll_route_pkg::fifo_level_t fifo_level_i,
  input  logic                        fifo_full_i
);

  // Decode of the pending bus cycle
  logic                        bus_req;
  logic                        wr_id;
  logic                        wr_req;
  logic                        rd_res;
  logic                        space_ok;
  logic                        accept;
  logic [3:0]                  occupancy;
  logic [`COLL_WB_DW-1:0]      rd_data;

  // Requests issued but not yet pushed into the queue
  coll_route_pkg::fifo_level_t inflight_q;
  // Copy of the stage pipeline, bit 1 marks the push cycle
  logic [1:0]                  pipe_q;

  // --------------------
  // Address decode
  // --------------------

  // The cycle after ack is skipped so a held strobe is not taken twice
  assign bus_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_id   = bus_req && wb_we_i && (wb_adr_i == `COLL_ADDR_ID);
  assign wr_req  = bus_req && wb_we_i && (wb_adr_i == `COLL_ADDR_REQ);
  assign rd_res  = bus_req && !wb_we_i && (wb_adr_i == `COLL_ADDR_RES);

  // Results already queued plus those still in the stage must leave a free slot
  assign occupancy = {1'b0, fifo_level_i} + {1'b0, inflight_q};
  assign space_ok  = !fifo_full_i && (occupancy < 4'(`COLL_FIFO_DEPTH));

  // Only a REQ write can be held back
  assign accept = bus_req && !(wr_req && !space_ok);

  // Pop when the read is taken and there is something to pop
  assign fifo_pop_o = rd_res && (fifo_level_i != '0);

  // Read data mux, unmapped bits read as zero
  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      `COLL_ADDR_ID: begin
        rd_data[$bits(coll_route_pkg::xy_id_t)-1:0] = router_id_o;
      end
      `COLL_ADDR_RES: begin
        // Empty queue returns zero with valid clear
        if (fifo_level_i != '0) begin
          rd_data[$bits(coll_route_pkg::coll_res_t)] = 1'b1;
          rd_data[$bits(coll_route_pkg::coll_res_t)-1:0] = fifo_data_i;
        end
      end
      `COLL_ADDR_STAT: begin
        rd_data[$bits(coll_route_pkg::fifo_level_t)-1:0] = fifo_level_i;
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // --------------------
  // Control registers
  // --------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o      <= 1'b0;
      issue_valid_o <= 1'b0;
      router_id_o   <= '0;
      inflight_q    <= '0;
      pipe_q        <= '0;
    end else begin
      wb_ack_o      <= accept;
      issue_valid_o <= wr_req && space_ok;
      if (wr_id) begin
        router_id_o <= coll_route_pkg::xy_id_t'(wb_dat_i[$bits(coll_route_pkg::xy_id_t)-1:0]);
      end
      // Result lands in the queue two cycles after the issue pulse
      pipe_q <= {pipe_q[0], issue_valid_o};
      case ({wr_req && space_ok, pipe_q[1]})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // Read data for the ack cycle and the header for the issue pulse
  always_ff @(posedge clk_i) begin
    if (accept) begin
      wb_dat_o <= rd_data;
    end
    if (wr_req && space_ok) begin
      issue_hdr_o <= coll_route_pkg::coll_hdr_t'(wb_dat_i[$bits(coll_route_pkg::coll_hdr_t)-1:0]);
    end
  end

  // Each accepted cycle gets exactly one ack pulse
  a_ack_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

// File: coll_route_top.sv
// Collective route-mask unit
`timescale 1ns/1ns
`include "coll_route_defs.svh"

module coll_route_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [1:0]             wb_adr_i,
  input  logic [`COLL_WB_DW-1:0] wb_dat_i,
  output logic [`COLL_WB_DW-1:0] wb_dat_o,
  output logic                   wb_ack_o
);

  // Bus block to stage
  logic                        issue_valid;
  coll_route_pkg::coll_hdr_t   issue_hdr;
  coll_route_pkg::xy_id_t      router_id;

  // Stage to queue
  logic                        res_valid;
  coll_route_pkg::coll_res_t   res;

  // Queue back to the bus block
  logic                        fifo_pop;
  coll_route_pkg::coll_res_t   fifo_data;
  coll_route_pkg::fifo_level_t fifo_level;
  logic                        fifo_full;

  coll_wb_regs u_regs (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .issue_valid_o (issue_valid),
    .issue_hdr_o   (issue_hdr),
    .router_id_o   (router_id),
    .fifo_pop_o    (fifo_pop),
    .fifo_data_i   (fifo_data),
    .fifo_level_i  (fifo_level),
    .fifo_full_i   (fifo_full)
  );

  coll_route_stage u_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (issue_valid),
    .hdr_i    (issue_hdr),
    .xy_id_i  (router_id),
    .valid_o  (res_valid),
    .res_o    (res)
  );

  coll_result_fifo u_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (res_valid),
    .data_i   (res),
    .pop_i    (fifo_pop),
    .data_o   (fifo_data),
    .level_o  (fifo_level),
    .full_o   (fifo_full)
  );

endmodule

// File: tb_coll_route.sv
// Collective route unit testbench
`timescale 1ns/1ns
`include "coll_route_defs.svh"

module tb_coll_route;

  // Random headers in the main loop, plus a bound on the directed and stall requests
  localparam int n_random        = 300;
  localparam int n_directed      = 16;
  localparam int watchdog_cycles = (n_random + n_directed) * 40 + 2000;
  localparam int ack_limit       = 64;
  localparam int poll_limit      = 32;
  localparam int stall_cycles    = 16;

  logic                   clk;
  logic                   arst_n;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [1:0]             wb_adr;
  logic [`COLL_WB_DW-1:0] wb_dat_w;
  logic [`COLL_WB_DW-1:0] wb_dat_r;
  logic                   wb_ack;

  // Expected results, in the order the DUT has to return them
  coll_route_pkg::coll_res_t exp_q[$];
  // Router id the DUT holds right now
  coll_route_pkg::xy_id_t    cur_id;

  coll_route_top UUT (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // Error handling
  // --------------------

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  // Whole RES word, valid in bit 10 and nothing above it
  task automatic check_res(input string what, input logic [`COLL_WB_DW-1:0] word,
                           input logic exp_valid, input coll_route_pkg::coll_res_t exp);
    logic [`COLL_WB_DW-1:0] exp_word;
    exp_word = '0;
    exp_word[$bits(coll_route_pkg::coll_res_t)] = exp_valid;
    exp_word[$bits(coll_route_pkg::coll_res_t)-1:0] = exp;
    if (word !== exp_word) begin
      stop_on_error($sformatf("Fail wb_dat_o %s: got %h expected %h", what, word, exp_word));
    end
  endtask

  task automatic check_id(input string what, input coll_route_pkg::xy_id_t got,
                          input coll_route_pkg::xy_id_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail router_id %s: got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_level(input string what, input coll_route_pkg::fifo_level_t got,
                             input coll_route_pkg::fifo_level_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail fifo_level %s: got %h expected %h", what, got, exp));
    end
  endtask

  // --------------------
  // Reference model
  // --------------------

  // True when every coordinate bit is a wildcard or equal to ours
  function automatic logic axis_hit(input coll_route_pkg::coord_t me,
                                    input coll_route_pkg::coord_t c,
                                    input coll_route_pkg::coord_t m);
    logic hit;
    int   b;
    hit = 1'b1;
    for (b = 0; b < `COLL_XY_WIDTH; b++) begin
      if (!m[b] && (me[b] != c[b])) begin
        hit = 1'b0;
      end
    end
    return hit;
  endfunction

  function automatic coll_route_pkg::coll_res_t model_masks(input coll_route_pkg::coll_hdr_t h,
                                                            input coll_route_pkg::xy_id_t me);
    coll_route_pkg::coll_res_t r;
    coll_route_pkg::xy_id_t    d_hi;
    coll_route_pkg::xy_id_t    d_lo;
    coll_route_pkg::xy_id_t    s_hi;
    coll_route_pkg::xy_id_t    s_lo;
    logic                      d_x;
    logic                      d_y;
    logic                      s_x;
    logic                      s_y;
    r = '0;
    // Wildcard bits set give the far corner of a set, cleared the near one
    d_hi.x = h.dst_id.x | h.mask.x;
    d_hi.y = h.dst_id.y | h.mask.y;
    d_lo.x = h.dst_id.x & ~h.mask.x;
    d_lo.y = h.dst_id.y & ~h.mask.y;
    s_hi.x = h.src_id.x | h.mask.x;
    s_hi.y = h.src_id.y | h.mask.y;
    s_lo.x = h.src_id.x & ~h.mask.x;
    s_lo.y = h.src_id.y & ~h.mask.y;
    d_x = axis_hit(me.x, h.dst_id.x, h.mask.x);
    d_y = axis_hit(me.y, h.dst_id.y, h.mask.y);
    s_x = axis_hit(me.x, h.src_id.x, h.mask.x);
    s_y = axis_hit(me.y, h.src_id.y, h.mask.y);
    // Multicast runs along the source row, then along destination columns
    r.fwd_mask[coll_route_pkg::Eject] = d_x && d_y;
    if (me.y == h.src_id.y) begin
      r.fwd_mask[coll_route_pkg::East] = (me.x >= h.src_id.x) && (me.x < d_hi.x);
      r.fwd_mask[coll_route_pkg::West] = (me.x <= h.src_id.x) && (me.x > d_lo.x);
    end
    if (d_x) begin
      r.fwd_mask[coll_route_pkg::North] = (me.y >= h.src_id.y) && (me.y < d_hi.y);
      r.fwd_mask[coll_route_pkg::South] = (me.y <= h.src_id.y) && (me.y > d_lo.y);
    end
    // Reduction folds rows toward the destination column, then the column itself
    r.exp_in_mask[coll_route_pkg::Eject] = s_x && s_y;
    if (me.x == h.dst_id.x) begin
      r.exp_in_mask[coll_route_pkg::North] = (me.y >= h.dst_id.y) && (me.y < s_hi.y);
      r.exp_in_mask[coll_route_pkg::South] = (me.y <= h.dst_id.y) && (me.y > s_lo.y);
    end
    if (s_y) begin
      r.exp_in_mask[coll_route_pkg::East] = (me.x >= h.dst_id.x) && (me.x < s_hi.x);
      r.exp_in_mask[coll_route_pkg::West] = (me.x <= h.dst_id.x) && (me.x > s_lo.x);
    end
    return r;
  endfunction

  // --------------------
  // Bus access
  // --------------------

  // One classic cycle, signals held until ack and sampled 1 ns after the edge
  task automatic bus_cycle(input logic we, input logic [1:0] adr,
                           input logic [`COLL_WB_DW-1:0] wdata,
                           output logic [`COLL_WB_DW-1:0] rdata);
    int waited;
    waited = 0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    @(posedge clk);
    #1;
    while (!wb_ack) begin
      waited++;
      if (waited >= ack_limit) begin
        stop_on_error("A bus cycle was never acknowledged");
      end
      @(posedge clk);
      #1;
    end
    rdata = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic bus_write(input logic [1:0] adr, input logic [`COLL_WB_DW-1:0] data);
    logic [`COLL_WB_DW-1:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic bus_read(input logic [1:0] adr, output logic [`COLL_WB_DW-1:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  // --------------------
  // Test steps
  // --------------------

  function automatic coll_route_pkg::coll_hdr_t rand_header();
    int unsigned rnd;
    rnd = $urandom;
    return coll_route_pkg::coll_hdr_t'(rnd[$bits(coll_route_pkg::coll_hdr_t)-1:0]);
  endfunction

  task automatic set_router_id(input coll_route_pkg::xy_id_t id);
    bus_write(`COLL_ADDR_ID, {{(`COLL_WB_DW-$bits(id)){1'b0}}, id});
    cur_id = id;
  endtask

  task automatic issue_request(input coll_route_pkg::coll_hdr_t hdr);
    bus_write(`COLL_ADDR_REQ, {{(`COLL_WB_DW-$bits(hdr)){1'b0}}, hdr});
    exp_q.push_back(model_masks(hdr, cur_id));
  endtask

  // Poll STAT until every issued request has landed in the queue
  task automatic wait_for_results();
    logic [`COLL_WB_DW-1:0] word;
    int                     polls;
    polls = 0;
    bus_read(`COLL_ADDR_STAT, word);
    while (int'(word[2:0]) != exp_q.size()) begin
      polls++;
      if (polls >= poll_limit) begin
        stop_on_error("Issued requests did not reach the result queue in time");
      end
      bus_read(`COLL_ADDR_STAT, word);
    end
  endtask

  // Read the head result, then check that the queue shrank by one
  task automatic drain_one(input string what);
    logic [`COLL_WB_DW-1:0]    word;
    coll_route_pkg::coll_res_t exp;
    exp = exp_q.pop_front();
    bus_read(`COLL_ADDR_RES, word);
    check_res(what, word, 1'b1, exp);
    bus_read(`COLL_ADDR_STAT, word);
    check_level({what, " STAT"}, word[2:0], coll_route_pkg::fifo_level_t'(exp_q.size()));
  endtask

  task automatic directed_case(input string what, input coll_route_pkg::xy_id_t me,
                               input coll_route_pkg::coll_hdr_t hdr);
    set_router_id(me);
    issue_request(hdr);
    wait_for_results();
    drain_one(what);
  endtask

  // Fill the queue, hold one more REQ, then free a slot and let it through
  task automatic check_stall();
    coll_route_pkg::coll_hdr_t hdr;
    int                        i;
    for (i = 0; i < `COLL_FIFO_DEPTH; i++) begin
      issue_request(rand_header());
    end
    hdr = rand_header();
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = `COLL_ADDR_REQ;
    wb_dat_w = {{(`COLL_WB_DW-$bits(hdr)){1'b0}}, hdr};
    repeat (stall_cycles) begin
      @(posedge clk);
      #1;
      if (wb_ack) begin
        stop_on_error("A REQ write was acknowledged while the result queue was full");
      end
    end
    // Master gives up the held cycle so that it can read
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wait_for_results();
    drain_one("RES stall release");
    issue_request(hdr);
    wait_for_results();
    while (exp_q.size() > 0) begin
      drain_one("RES after stall");
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    logic [`COLL_WB_DW-1:0] word;
    int                     done;
    int                     batch;
    int unsigned            rnd;
    void'($urandom(32'hbbe7_2245));
    cur_id = '0;
    arst_n = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(posedge clk);
    #1;

    // Reset values, then an ID write read back
    bus_read(`COLL_ADDR_ID, word);
    check_id("ID after reset", word[5:0], '0);
    bus_read(`COLL_ADDR_STAT, word);
    check_level("STAT after reset", word[2:0], '0);
    set_router_id(6'o52);
    bus_read(`COLL_ADDR_ID, word);
    check_id("ID readback", word[5:0], 6'o52);

    // Octal pairs are x then y, the header is mask, src, dst
    // Router at the destination with no wildcards forwards to Eject only
    directed_case("RES eject only", 6'o34, {6'o00, 6'o12, 6'o34});
    // Full wildcard around a centre router opens every port both ways
    directed_case("RES full mask centre", 6'o33, {6'o77, 6'o33, 6'o33});
    directed_case("RES full mask corner", 6'o00, {6'o77, 6'o55, 6'o22});
    directed_case("RES partial mask", 6'o47, {6'o21, 6'o40, 6'o65});

    // Random ids, each followed by a batch that fits in the queue
    done = 0;
    while (done < n_random) begin
      rnd = $urandom;
      set_router_id(coll_route_pkg::xy_id_t'(rnd[5:0]));
      batch = 1 + int'($urandom % `COLL_FIFO_DEPTH);
      if (batch > n_random - done) begin
        batch = n_random - done;
      end
      repeat (batch) issue_request(rand_header());
      wait_for_results();
      repeat (batch) drain_one("RES random");
      done += batch;
    end

    // An empty queue reads as zero and is not popped
    bus_read(`COLL_ADDR_RES, word);
    check_res("RES on empty queue", word, 1'b0, '0);
    bus_read(`COLL_ADDR_STAT, word);
    check_level("STAT on empty queue", word[2:0], '0);

    check_stall();

    $display("Simulation finished: PASS");
    $finish;
  end

  // Bounded by the number of requests, each one well under 40 cycles
  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    stop_on_error("Watchdog expired before the tests finished");
  end

endmodule

// File: coll_route.f
+incdir+.
coll_route_pkg.sv
coll_route_xymask.sv
coll_route_stage.sv
coll_result_fifo.sv
coll_wb_regs.sv
coll_route_top.sv
tb_coll_route.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_coll_route -f coll_route.f \
  -o tb_coll_route > sim.log 2>&1 \
  && ./obj_dir/tb_coll_route >> sim.log 2>&1 \
  || echo "Build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "Simulation finished: PASS" sim.log && echo "Result: pass" && exit 0 \
  || { echo "Result: fail"; exit 1; }
